// File: src/e310_core_config.svh
// e310 bus-clock core constants
// settings addresses, readback codes, build identity and buffer sizing
`ifndef E310_CORE_CONFIG_SVH
`define E310_CORE_CONFIG_SVH

// settings bus register offsets
`define E310_SR_READBACK    8'h00
`define E310_SR_MISC        8'h04
`define E310_SR_TEST        8'h1c
`define E310_SR_XB_LOCAL    8'h20
`define E310_SR_CNT_CLEAR   8'h24

// readback select codes
`define E310_RB_MISC        5'd1
`define E310_RB_COMPAT      5'd2
`define E310_RB_GITHASH     5'd3
`define E310_RB_PLL         5'd4
`define E310_RB_CNT_BASE    5'd8
`define E310_RB_TEST        5'd24

// identity words
`define E310_COMPAT         32'hac000e00
`define E310_GIT_HASH       32'h6c3e91d7
`define E310_XB_LOCAL_RESET 8'd40

// engine buffering in beats
`define E310_ENGINE_FIFO_DEPTH 16

`endif

// File: src/e310_core_pkg.sv
// e310 core shared types
// stream beat layout, routing destinations and packet count width
`default_nettype none

package e310_core_pkg;

  // one stream beat as stored in the engine buffers
  typedef struct packed {
    logic        last;
    logic [63:0] data;
  } stream_beat_t;

  // destination port in the low bits of the first beat
  typedef enum logic [1:0] {
    HOST    = 2'd0,
    ENGINE0 = 2'd1,
    ENGINE1 = 2'd2,
    DROP    = 2'd3
  } dest_port_t;

  // per-destination packet count
  typedef logic [15:0] pkt_count_t;

endpackage

`default_nettype wire

// File: src/stream_if.sv
// 64-bit packet stream with valid/ready/last handshake
`default_nettype none

interface stream_if;

  logic [63:0] tdata;
  logic        tlast;
  logic        tvalid;
  logic        tready;

  // beat producer
  modport source (
    output tdata,
    output tlast,
    output tvalid,
    input  tready
  );

  // beat consumer
  modport sink (
    input  tdata,
    input  tlast,
    input  tvalid,
    output tready
  );

endinterface

`default_nettype wire

// File: src/core_settings.sv
// global settings registers and readback for the e310 core
// drives board controls, resyncs pll lock bits, muxes status for readback
`default_nettype none

`include "e310_core_config.svh"

module core_settings (
  input  wire                             bus_clk,
  input  wire                             bus_rst,
  input  wire                      [31:0] i_set_data,
  input  wire                       [7:0] i_set_addr,
  input  wire                             i_set_stb,
  input  wire                       [3:0] i_tcxo_status,
  input  wire                       [1:0] i_lock_signals,
  input  wire e310_core_pkg::pkt_count_t [3:0] i_pkt_counts,
  output logic                     [31:0] o_rb_data,
  output logic                      [7:0] o_xb_local_addr,
  output logic                            o_cnt_clear,
  output logic                      [1:0] o_pps_select,
  output logic                            o_mimo,
  output logic                            o_codec_arst,
  output logic                      [2:0] o_tx_bandsel,
  output logic                      [5:0] o_rx_bandsel_a,
  output logic                      [3:0] o_rx_bandsel_b,
  output logic                      [3:0] o_rx_bandsel_c
);

  logic  [4:0] rb_addr;
  logic [31:0] test_word;
  logic [20:0] misc;
  logic  [1:0] lock_meta;
  logic  [1:0] lock_sync;

  //////////////////////////////////////////////////
  // register writes
  //////////////////////////////////////////////////

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      rb_addr         <= 5'd0;
      test_word       <= 32'd0;
      // internal pps source by default
      misc            <= 21'd2;
      o_xb_local_addr <= `E310_XB_LOCAL_RESET;
      o_cnt_clear     <= 1'b0;
    end else begin
      o_cnt_clear <= i_set_stb && (i_set_addr == `E310_SR_CNT_CLEAR);
      if (i_set_stb) begin
        case (i_set_addr)
          `E310_SR_READBACK: rb_addr         <= i_set_data[4:0];
          `E310_SR_TEST:     test_word       <= i_set_data;
          `E310_SR_MISC:     misc            <= i_set_data[20:0];
          `E310_SR_XB_LOCAL: o_xb_local_addr <= i_set_data[7:0];
          default: ;
        endcase
      end
    end
  end

  // misc word fields
  assign o_pps_select   = misc[1:0];
  assign o_mimo         = misc[2];
  assign o_codec_arst   = misc[3];
  assign o_tx_bandsel   = misc[6:4];
  assign o_rx_bandsel_a = misc[12:7];
  assign o_rx_bandsel_b = misc[16:13];
  assign o_rx_bandsel_c = misc[20:17];

  // lock bits come from the radio chip, two-flop resync
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      lock_meta <= 2'b00;
      lock_sync <= 2'b00;
    end else begin
      lock_meta <= i_lock_signals;
      lock_sync <= lock_meta;
    end
  end

  //////////////////////////////////////////////////
  // readback mux
  //////////////////////////////////////////////////

  always_comb begin
    case (rb_addr)
      `E310_RB_MISC:            o_rb_data = {26'd0, i_tcxo_status, o_pps_select};
      `E310_RB_COMPAT:          o_rb_data = `E310_COMPAT;
      `E310_RB_GITHASH:         o_rb_data = `E310_GIT_HASH;
      `E310_RB_PLL:             o_rb_data = {30'd0, lock_sync};
      `E310_RB_TEST:            o_rb_data = test_word;
      `E310_RB_CNT_BASE:        o_rb_data = {16'd0, i_pkt_counts[0]};
      `E310_RB_CNT_BASE + 5'd1: o_rb_data = {16'd0, i_pkt_counts[1]};
      `E310_RB_CNT_BASE + 5'd2: o_rb_data = {16'd0, i_pkt_counts[2]};
      `E310_RB_CNT_BASE + 5'd3: o_rb_data = {16'd0, i_pkt_counts[3]};
      default:                  o_rb_data = 32'hdeadbeef;
    endcase
  end

endmodule

`default_nettype wire

// File: src/route_ctrl.sv
// per-packet router control
// decodes the destination of each first beat and owns the input ready
`default_nettype none

module route_ctrl (
  input  wire                        bus_clk,
  input  wire                        bus_rst,
  input  wire                  [7:0] i_xb_local_addr,
  stream_if.sink                     in,
  input  wire                  [2:0] i_sink_ready,
  output e310_core_pkg::dest_port_t  o_port,
  output logic                       o_active,
  output logic                       o_pkt_done
);

  typedef enum logic {
    ST_IDLE,
    ST_FORWARD
  } state_t;

  state_t                    state;
  e310_core_pkg::dest_port_t dest;
  logic                      sel_ready;

  // local packets pick their port, everything else goes home
  always_comb begin
    if (in.tdata[15:8] == i_xb_local_addr) begin
      dest = e310_core_pkg::dest_port_t'(in.tdata[1:0]);
    end else begin
      dest = e310_core_pkg::HOST;
    end
  end

  assign o_active = (state == ST_FORWARD);

  // drop path always accepts
  assign sel_ready = (o_port == e310_core_pkg::DROP) || (|i_sink_ready);

  assign in.tready  = o_active && sel_ready;
  assign o_pkt_done = in.tvalid && in.tready && in.tlast;

  //////////////////////////////////////////////////
  // routing state machine
  //////////////////////////////////////////////////

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      state  <= ST_IDLE;
      o_port <= e310_core_pkg::HOST;
    end else begin
      case (state)
        ST_IDLE: begin
          // one decode cycle before the first beat moves
          if (in.tvalid) begin
            o_port <= dest;
            state  <= ST_FORWARD;
          end
        end
        ST_FORWARD: begin
          if (o_pkt_done) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/stream_switch.sv
// one-to-three stream demux with drop path
// steered by the latched port from the router control
`default_nettype none

module stream_switch (
  input  wire e310_core_pkg::dest_port_t i_port,
  input  wire                       i_active,
  stream_if.sink                    in,
  output logic               [63:0] o_host_tdata,
  output logic                      o_host_tlast,
  output logic                      o_host_tvalid,
  input  wire                       i_host_tready,
  stream_if.source                  eng0,
  stream_if.source                  eng1,
  output logic                [2:0] o_in_ready
);

  // one-hot sink select, all zero for drop
  logic [2:0] sel;

  always_comb begin
    sel = 3'b000;
    case (i_port)
      e310_core_pkg::HOST:    sel[0] = 1'b1;
      e310_core_pkg::ENGINE0: sel[1] = 1'b1;
      e310_core_pkg::ENGINE1: sel[2] = 1'b1;
      default: ;
    endcase
  end

  // data fans out, only the selected valid is raised
  assign o_host_tdata  = in.tdata;
  assign o_host_tlast  = in.tlast;
  assign o_host_tvalid = i_active && sel[0] && in.tvalid;

  assign eng0.tdata  = in.tdata;
  assign eng0.tlast  = in.tlast;
  assign eng0.tvalid = i_active && sel[1] && in.tvalid;

  assign eng1.tdata  = in.tdata;
  assign eng1.tlast  = in.tlast;
  assign eng1.tvalid = i_active && sel[2] && in.tvalid;

  // ready of the selected sink, masked per port
  assign o_in_ready = sel & {eng1.tready, eng0.tready, i_host_tready};

endmodule

`default_nettype wire

// File: src/stream_fifo.sv
// synchronous beat FIFO in front of an engine stream
`default_nettype none

`include "e310_core_config.svh"

module stream_fifo #(
  parameter int DEPTH = `E310_ENGINE_FIFO_DEPTH
) (
  input  wire      bus_clk,
  input  wire      bus_rst,
  stream_if.sink   in,
  stream_if.source out
);

  localparam int AW = $clog2(DEPTH);

  e310_core_pkg::stream_beat_t mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic   [AW:0] count;
  logic          wr_en;
  logic          rd_en;

  assign in.tready  = (count != (AW+1)'(DEPTH));
  assign out.tvalid = (count != '0);
  assign wr_en      = in.tvalid && in.tready;
  assign rd_en      = out.tvalid && out.tready;

  assign out.tdata = mem[rd_ptr].data;
  assign out.tlast = mem[rd_ptr].last;

  // storage
  always_ff @(posedge bus_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= '{last: in.tlast, data: in.tdata};
    end
  end

  // pointers wrap at depth, not at a power of two
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/pkt_counter.sv
// per-destination packet counters for status readback
`default_nettype none

module pkt_counter (
  input  wire                              bus_clk,
  input  wire                              bus_rst,
  input  wire                              i_clear,
  input  wire                              i_pkt_done,
  input  wire e310_core_pkg::dest_port_t   i_port,
  output e310_core_pkg::pkt_count_t  [3:0] o_counts
);

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      o_counts <= '0;
    end else if (i_clear) begin
      // a clear in the same cycle as a packet end discards that packet
      o_counts <= '0;
    end else if (i_pkt_done) begin
      o_counts[i_port] <= o_counts[i_port] + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/e310_core.sv
// e310 bus-clock core
// settings registers, host packet router and buffered engine streams
`default_nettype none

module e310_core (
  input  wire        bus_clk,
  input  wire        bus_rst,

  // settings bus
  input  wire [31:0] i_set_data,
  input  wire  [7:0] i_set_addr,
  input  wire        i_set_stb,
  output logic [31:0] o_rb_data,

  // host to core stream
  input  wire [63:0] i_h2s_tdata,
  input  wire        i_h2s_tlast,
  input  wire        i_h2s_tvalid,
  output logic       o_h2s_tready,

  // core to host stream
  output logic [63:0] o_s2h_tdata,
  output logic        o_s2h_tlast,
  output logic        o_s2h_tvalid,
  input  wire         i_s2h_tready,

  // engine streams
  output logic [63:0] o_ce0_tdata,
  output logic        o_ce0_tlast,
  output logic        o_ce0_tvalid,
  input  wire         i_ce0_tready,
  output logic [63:0] o_ce1_tdata,
  output logic        o_ce1_tlast,
  output logic        o_ce1_tvalid,
  input  wire         i_ce1_tready,

  // board status and controls
  input  wire  [3:0] i_tcxo_status,
  input  wire  [1:0] i_lock_signals,
  output logic [1:0] o_pps_select,
  output logic       o_mimo,
  output logic       o_codec_arst,
  output logic [2:0] o_tx_bandsel,
  output logic [5:0] o_rx_bandsel_a,
  output logic [3:0] o_rx_bandsel_b,
  output logic [3:0] o_rx_bandsel_c
);

  logic                                [7:0] xb_local_addr;
  logic                                      cnt_clear;
  e310_core_pkg::pkt_count_t           [3:0] pkt_counts;
  e310_core_pkg::dest_port_t                 route_port;
  logic                                      route_active;
  logic                                      pkt_done;
  logic                                [2:0] sink_ready;

  stream_if h2s_if ();
  stream_if eng0_if ();
  stream_if eng1_if ();
  stream_if ce0_if ();
  stream_if ce1_if ();

  //////////////////////////////////////////////////
  // settings and status
  //////////////////////////////////////////////////

  core_settings u_settings (
    .bus_clk         (bus_clk),
    .bus_rst         (bus_rst),
    .i_set_data      (i_set_data),
    .i_set_addr      (i_set_addr),
    .i_set_stb       (i_set_stb),
    .i_tcxo_status   (i_tcxo_status),
    .i_lock_signals  (i_lock_signals),
    .i_pkt_counts    (pkt_counts),
    .o_rb_data       (o_rb_data),
    .o_xb_local_addr (xb_local_addr),
    .o_cnt_clear     (cnt_clear),
    .o_pps_select    (o_pps_select),
    .o_mimo          (o_mimo),
    .o_codec_arst    (o_codec_arst),
    .o_tx_bandsel    (o_tx_bandsel),
    .o_rx_bandsel_a  (o_rx_bandsel_a),
    .o_rx_bandsel_b  (o_rx_bandsel_b),
    .o_rx_bandsel_c  (o_rx_bandsel_c)
  );

  pkt_counter u_counter (
    .bus_clk    (bus_clk),
    .bus_rst    (bus_rst),
    .i_clear    (cnt_clear),
    .i_pkt_done (pkt_done),
    .i_port     (route_port),
    .o_counts   (pkt_counts)
  );

  //////////////////////////////////////////////////
  // host packet routing
  //////////////////////////////////////////////////

  assign h2s_if.tdata  = i_h2s_tdata;
  assign h2s_if.tlast  = i_h2s_tlast;
  assign h2s_if.tvalid = i_h2s_tvalid;
  assign o_h2s_tready  = h2s_if.tready;

  route_ctrl u_route (
    .bus_clk         (bus_clk),
    .bus_rst         (bus_rst),
    .i_xb_local_addr (xb_local_addr),
    .in              (h2s_if),
    .i_sink_ready    (sink_ready),
    .o_port          (route_port),
    .o_active        (route_active),
    .o_pkt_done      (pkt_done)
  );

  stream_switch u_switch (
    .i_port        (route_port),
    .i_active      (route_active),
    .in            (h2s_if),
    .o_host_tdata  (o_s2h_tdata),
    .o_host_tlast  (o_s2h_tlast),
    .o_host_tvalid (o_s2h_tvalid),
    .i_host_tready (i_s2h_tready),
    .eng0          (eng0_if),
    .eng1          (eng1_if),
    .o_in_ready    (sink_ready)
  );

  // engine buffering
  stream_fifo u_ce0_fifo (
    .bus_clk (bus_clk),
    .bus_rst (bus_rst),
    .in      (eng0_if),
    .out     (ce0_if)
  );

  stream_fifo u_ce1_fifo (
    .bus_clk (bus_clk),
    .bus_rst (bus_rst),
    .in      (eng1_if),
    .out     (ce1_if)
  );

  assign o_ce0_tdata   = ce0_if.tdata;
  assign o_ce0_tlast   = ce0_if.tlast;
  assign o_ce0_tvalid  = ce0_if.tvalid;
  assign ce0_if.tready = i_ce0_tready;

  assign o_ce1_tdata   = ce1_if.tdata;
  assign o_ce1_tlast   = ce1_if.tlast;
  assign o_ce1_tvalid  = ce1_if.tvalid;
  assign ce1_if.tready = i_ce1_tready;

endmodule

`default_nettype wire

// File: testbench/tb_e310_core.sv
// testbench for the e310 bus-clock core
// settings, routing and back-pressure checks against per-sink scoreboards
`default_nettype none

`include "e310_core_config.svh"

module tb_e310_core;

  timeunit 1ns;
  timeprecision 100ps;

  // about 700 cycles of settings and traffic plus a wide margin
  localparam int MAX_CYCLES = 4000;

  logic        bus_clk;
  logic        bus_rst;
  logic [31:0] i_set_data;
  logic  [7:0] i_set_addr;
  logic        i_set_stb;
  logic [31:0] o_rb_data;
  logic [63:0] i_h2s_tdata;
  logic        i_h2s_tlast;
  logic        i_h2s_tvalid;
  logic        o_h2s_tready;
  logic [63:0] o_s2h_tdata;
  logic        o_s2h_tlast;
  logic        o_s2h_tvalid;
  logic        i_s2h_tready;
  logic [63:0] o_ce0_tdata;
  logic        o_ce0_tlast;
  logic        o_ce0_tvalid;
  logic        i_ce0_tready;
  logic [63:0] o_ce1_tdata;
  logic        o_ce1_tlast;
  logic        o_ce1_tvalid;
  logic        i_ce1_tready;
  logic  [3:0] i_tcxo_status;
  logic  [1:0] i_lock_signals;
  logic  [1:0] o_pps_select;
  logic        o_mimo;
  logic        o_codec_arst;
  logic  [2:0] o_tx_bandsel;
  logic  [5:0] o_rx_bandsel_a;
  logic  [3:0] o_rx_bandsel_b;
  logic  [3:0] o_rx_bandsel_c;

  // expected beats per sink as {last, data}
  logic [64:0] exp_s2h [$];
  logic [64:0] exp_ce0 [$];
  logic [64:0] exp_ce1 [$];
  logic        held_valid [3];
  logic [64:0] held_beat [3];
  int          exp_counts [4];
  logic  [7:0] local_addr;
  int          ready_pct;
  int          cycles = 0;

  e310_core uut (
    .bus_clk (bus_clk), .bus_rst (bus_rst),
    .i_set_data (i_set_data), .i_set_addr (i_set_addr), .i_set_stb (i_set_stb),
    .o_rb_data (o_rb_data),
    .i_h2s_tdata (i_h2s_tdata), .i_h2s_tlast (i_h2s_tlast),
    .i_h2s_tvalid (i_h2s_tvalid), .o_h2s_tready (o_h2s_tready),
    .o_s2h_tdata (o_s2h_tdata), .o_s2h_tlast (o_s2h_tlast),
    .o_s2h_tvalid (o_s2h_tvalid), .i_s2h_tready (i_s2h_tready),
    .o_ce0_tdata (o_ce0_tdata), .o_ce0_tlast (o_ce0_tlast),
    .o_ce0_tvalid (o_ce0_tvalid), .i_ce0_tready (i_ce0_tready),
    .o_ce1_tdata (o_ce1_tdata), .o_ce1_tlast (o_ce1_tlast),
    .o_ce1_tvalid (o_ce1_tvalid), .i_ce1_tready (i_ce1_tready),
    .i_tcxo_status (i_tcxo_status), .i_lock_signals (i_lock_signals),
    .o_pps_select (o_pps_select), .o_mimo (o_mimo), .o_codec_arst (o_codec_arst),
    .o_tx_bandsel (o_tx_bandsel), .o_rx_bandsel_a (o_rx_bandsel_a),
    .o_rx_bandsel_b (o_rx_bandsel_b), .o_rx_bandsel_c (o_rx_bandsel_c)
  );

  initial begin
    bus_clk = 1'b0;
    forever #2 bus_clk = ~bus_clk;
  end

  task automatic report_fail(input string msg);
    $display("FAILED at %0d ns: %s", $time, msg);
    $display(">>> FAIL");
    $fatal(1, "check failed");
  endtask

  // local address match picks the low two bits and anything else goes to host
  function automatic int expected_port(input logic [63:0] first, input logic [7:0] local_id);
    if (first[15:8] == local_id) begin
      return int'(first[1:0]);
    end
    return 0;
  endfunction

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    i_set_addr = addr;
    i_set_data = data;
    i_set_stb  = 1'b1;
    @(posedge bus_clk);
    #1;
    i_set_stb = 1'b0;
  endtask

  task automatic read_reg(input logic [4:0] code, output logic [31:0] value);
    write_reg(`E310_SR_READBACK, {27'd0, code});
    value = o_rb_data;
  endtask

  task automatic send_packet(input logic [7:0] addr, input logic [1:0] port, input int beats);
    logic [63:0] data;
    logic        last;
    logic        accepted;
    int          dst;
    int          n;
    dst = 0;
    for (n = 0; n < beats; n++) begin
      data = {$urandom, $urandom};
      last = (n == beats - 1);
      if (n == 0) begin
        data[15:8] = addr;
        data[1:0]  = port;
        dst = expected_port(data, local_addr);
        exp_counts[dst]++;
      end
      case (dst)
        0: exp_s2h.push_back({last, data});
        1: exp_ce0.push_back({last, data});
        2: exp_ce1.push_back({last, data});
        default: ;
      endcase
      i_h2s_tdata  = data;
      i_h2s_tlast  = last;
      i_h2s_tvalid = 1'b1;
      // hold the beat until the router takes it
      do begin
        @(negedge bus_clk);
        accepted = o_h2s_tready;
        @(posedge bus_clk);
        #1;
      end while (!accepted);
    end
    i_h2s_tvalid = 1'b0;
    i_h2s_tlast  = 1'b0;
  endtask

  task automatic wait_drain();
    do begin
      @(posedge bus_clk);
      #1;
    end while (exp_s2h.size() + exp_ce0.size() + exp_ce1.size() != 0);
  endtask

  // scoreboard compare plus hold check for one sink
  task automatic check_sink(input int idx, input logic valid, input logic ready,
                            input logic [64:0] beat);
    logic [64:0] exp;
    int          depth;
    if (held_valid[idx]) begin
      assert (valid && beat == held_beat[idx])
        else report_fail($sformatf("sink %0d dropped or changed a held beat", idx));
    end
    if (valid && ready) begin
      case (idx)
        0: depth = exp_s2h.size();
        1: depth = exp_ce0.size();
        default: depth = exp_ce1.size();
      endcase
      assert (depth > 0)
        else report_fail($sformatf("sink %0d got unexpected beat %h", idx, beat));
      case (idx)
        0: exp = exp_s2h.pop_front();
        1: exp = exp_ce0.pop_front();
        default: exp = exp_ce1.pop_front();
      endcase
      assert (beat == exp)
        else report_fail($sformatf("sink %0d got %h, expected %h", idx, beat, exp));
    end
    held_valid[idx] = valid && !ready;
    held_beat[idx]  = beat;
  endtask

  //////////////////////////////////////////////////
  // sink models and monitors
  //////////////////////////////////////////////////

  always @(posedge bus_clk) begin
    #1;
    i_s2h_tready = ($urandom % 100) < ready_pct;
    i_ce0_tready = ($urandom % 100) < ready_pct;
    i_ce1_tready = ($urandom % 100) < ready_pct;
  end

  // sample mid-cycle when all inputs have settled
  always @(negedge bus_clk) begin
    if (!bus_rst) begin
      check_sink(0, o_s2h_tvalid, i_s2h_tready, {o_s2h_tlast, o_s2h_tdata});
      check_sink(1, o_ce0_tvalid, i_ce0_tready, {o_ce0_tlast, o_ce0_tdata});
      check_sink(2, o_ce1_tvalid, i_ce1_tready, {o_ce1_tlast, o_ce1_tdata});
    end
  end

  always @(posedge bus_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display(">>> FAIL");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] rb;
    logic [20:0] misc_val;
    logic  [7:0] addr;
    int          i;
    void'($urandom(32'h480a));
    bus_rst = 1'b1;
    i_set_data = '0;
    i_set_addr = '0;
    i_set_stb = 1'b0;
    i_h2s_tdata = '0;
    i_h2s_tlast = 1'b0;
    i_h2s_tvalid = 1'b0;
    i_s2h_tready = 1'b0;
    i_ce0_tready = 1'b0;
    i_ce1_tready = 1'b0;
    i_tcxo_status = 4'ha;
    i_lock_signals = 2'b00;
    ready_pct = 75;
    local_addr = `E310_XB_LOCAL_RESET;
    exp_counts = '{default: 0};
    held_valid = '{default: 1'b0};
    repeat (2) @(posedge bus_clk);
    #1;
    bus_rst = 1'b0;

    // reset state
    assert (!o_s2h_tvalid && !o_ce0_tvalid && !o_ce1_tvalid && !o_h2s_tready)
      else report_fail("stream handshake outputs not idle after reset");
    assert (o_pps_select == 2'd2 && !o_mimo && !o_codec_arst && o_tx_bandsel == 3'd0)
      else report_fail("misc outputs wrong after reset");
    assert (o_rx_bandsel_a == 6'd0 && o_rx_bandsel_b == 4'd0 && o_rx_bandsel_c == 4'd0)
      else report_fail("band selects not zero after reset");
    for (i = 0; i < 4; i++) begin
      read_reg(5'(`E310_RB_CNT_BASE + i), rb);
      assert (rb == 32'd0) else report_fail($sformatf("counter %0d not zero", i));
    end

    // settings writes and readback
    misc_val = 21'h15a5ff;
    write_reg(`E310_SR_MISC, {11'd0, misc_val});
    assert (o_pps_select == misc_val[1:0] && o_mimo == misc_val[2] &&
            o_codec_arst == misc_val[3] && o_tx_bandsel == misc_val[6:4])
      else report_fail("misc write not on control outputs");
    assert (o_rx_bandsel_a == misc_val[12:7] && o_rx_bandsel_b == misc_val[16:13] &&
            o_rx_bandsel_c == misc_val[20:17])
      else report_fail("misc write not on band selects");
    read_reg(`E310_RB_MISC, rb);
    assert (rb == {26'd0, i_tcxo_status, misc_val[1:0]}) else report_fail("misc readback");
    write_reg(`E310_SR_TEST, 32'h5a3ce7b1);
    read_reg(`E310_RB_TEST, rb);
    assert (rb == 32'h5a3ce7b1) else report_fail("test word readback");
    read_reg(`E310_RB_COMPAT, rb);
    assert (rb == `E310_COMPAT) else report_fail("compat readback");
    read_reg(`E310_RB_GITHASH, rb);
    assert (rb == `E310_GIT_HASH) else report_fail("build hash readback");
    read_reg(5'd6, rb);
    assert (rb == 32'hdeadbeef) else report_fail("unknown code readback");

    // pll lock bits through the resync
    read_reg(`E310_RB_PLL, rb);
    assert (rb == 32'd0) else report_fail("pll readback not zero");
    i_lock_signals = 2'b10;
    repeat (2) @(posedge bus_clk);
    #1;
    assert (o_rb_data == 32'd2) else report_fail("lock change late in pll readback");

    // fixed routing with the default local address
    send_packet(local_addr, 2'd0, 3);
    send_packet(local_addr, 2'd1, 4);
    send_packet(local_addr, 2'd2, 2);
    send_packet(local_addr, 2'd3, 5);
    send_packet(8'h12, 2'd1, 3);
    send_packet(8'h12, 2'd3, 1);
    wait_drain();

    // new local address and heavy back-pressure
    write_reg(`E310_SR_XB_LOCAL, 32'h55);
    local_addr = 8'h55;
    ready_pct = 30;
    repeat (24) begin
      case ($urandom % 3)
        0: addr = local_addr;
        1: addr = 8'd40;
        default: addr = 8'($urandom);
      endcase
      send_packet(addr, 2'($urandom), 1 + int'($urandom % 8));
    end
    ready_pct = 75;
    wait_drain();

    // packet counts and clear
    for (i = 0; i < 4; i++) begin
      read_reg(5'(`E310_RB_CNT_BASE + i), rb);
      assert (rb == 32'(exp_counts[i]))
        else report_fail($sformatf("counter %0d is %0d, expected %0d", i, rb, exp_counts[i]));
    end
    write_reg(`E310_SR_CNT_CLEAR, 32'd0);
    for (i = 0; i < 4; i++) begin
      read_reg(5'(`E310_RB_CNT_BASE + i), rb);
      assert (rb == 32'd0) else report_fail($sformatf("counter %0d not cleared", i));
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: e310_core.f
+incdir+src
src/e310_core_pkg.sv
src/stream_if.sv
src/core_settings.sv
src/route_ctrl.sv
src/stream_switch.sv
src/stream_fifo.sv
src/pkt_counter.sv
src/e310_core.sv
testbench/tb_e310_core.sv

// File: Bender.yml
package:
  name: e310_core

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/e310_core_pkg.sv
      - src/stream_if.sv
      - src/core_settings.sv
      - src/route_ctrl.sv
      - src/stream_switch.sv
      - src/stream_fifo.sv
      - src/pkt_counter.sv
      - src/e310_core.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/tb_e310_core.sv
